// File: hw/bilinearInterp.sv
`timescale 1ns/10ps

module bilinearInterp #(
  parameter int angle = 45
) (
  input  logic           clk,
  input  logic           rst_n,
  input  imagePkg::quadT quad,
  output interpPkg::accT result
);
  import imagePkg::*;
  import interpPkg::*;

  // Weights are fixed when the design is elaborated.
  localparam weightSetT wts = dirWeights(angle, sampleRadius);

  quadT quadReg;
  accT  prodA;
  accT  prodB;
  accT  prodC;
  accT  prodD;
  accT  sumAB;
  accT  sumCD;
  accT  sumAll;

  // --------------------
  // Pipeline
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      quadReg <= '0;
    end else begin
      quadReg <= quad;
    end
  end

  // Products keep only their low 24 bits.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prodA <= '0;
      prodB <= '0;
      prodC <= '0;
      prodD <= '0;
    end else begin
      prodA <= accT'(wts.w1 * weightT'(quadReg.a));
      prodB <= accT'(wts.w2 * weightT'(quadReg.b));
      prodC <= accT'(wts.w3 * weightT'(quadReg.c));
      prodD <= accT'(wts.w4 * weightT'(quadReg.d));
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sumAB <= '0;
      sumCD <= '0;
    end else begin
      sumAB <= prodA + prodB;
      sumCD <= prodC + prodD;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sumAll <= '0;
    end else begin
      sumAll <= sumAB + sumCD;
    end
  end

  assign result = sumAll;

endmodule

// File: hw/imagePkg.sv
package imagePkg;

  // --------------------
  // Raster geometry
  // --------------------

  // Pixels per image row. The row buffer holds exactly one row.
  localparam int imgWidth = 16;

  localparam int colBits = $clog2(imgWidth);
  localparam int rowBits = 8;

  // --------------------
  // Pixel and position types
  // --------------------

  typedef logic [7:0] pixelT;

  typedef logic [colBits-1:0] colT;

  // Row index wraps, since frame height is not limited.
  typedef logic [rowBits-1:0] rowT;

  // Position of the bottom-right pixel of a 2x2 window.
  typedef struct packed {
    rowT row;
    colT col;
  } coordT;

  // A 2x2 window that ends at the current pixel.
  //   a b
  //   c d
  typedef struct packed {
    pixelT a;
    pixelT b;
    pixelT c;
    pixelT d;
  } quadT;

endpackage

// File: hw/interpPkg.sv
package interpPkg;

  // --------------------
  // Arithmetic types
  // --------------------

  // Q16 weight, so 24'h010000 stands for 1.0.
  typedef logic [23:0] weightT;

  // Products and sums are kept at 24 bits through the adder tree.
  typedef logic [23:0] accT;

  // --------------------
  // Sampling setup
  // --------------------

  localparam int sampleRadius = 3;
  localparam int numDirs = 4;

  // Order here matches the sample fields below.
  localparam int dirAngles [numDirs] = '{45, 135, 225, 315};

  // Weights w1 to w4 scale window pixels a to d.
  typedef struct packed {
    weightT w1;
    weightT w2;
    weightT w3;
    weightT w4;
  } weightSetT;

  typedef struct packed {
    imagePkg::pixelT s45;
    imagePkg::pixelT s135;
    imagePkg::pixelT s225;
    imagePkg::pixelT s315;
  } sampleSetT;

  // Each radius contributes three distinct weights. The four diagonal
  // directions are rotations of one another, so they reuse the same three
  // values in a different arrangement over the window.
  // Unknown radius or angle gives all-zero weights.
  function automatic weightSetT dirWeights(input int angle, input int radius);
    weightT x;
    weightT y;
    weightT z;
    weightSetT ws;
    case (radius)
      2: {x, y, z} = {24'h003E1D, 24'h0057D8, 24'h002BEC};
      3: {x, y, z} = {24'h001B4A, 24'h00C5A6, 24'h0003C4};
      4: {x, y, z} = {24'h002463, 24'h000789, 24'h00AFB0};
      5: {x, y, z} = {24'h003FAD, 24'h003739, 24'h00496B};
      6: {x, y, z} = {24'h002F0B, 24'h0092D6, 24'h000F12};
      7: {x, y, z} = {24'h000C37, 24'h0000A5, 24'h00E6EA};
      8: {x, y, z} = {24'h0039B3, 24'h001E24, 24'h006E73};
      default: {x, y, z} = '0;
    endcase
    case (angle)
      45: ws = '{w1: x, w2: y, w3: z, w4: x};
      135: ws = '{w1: z, w2: x, w3: x, w4: y};
      225: ws = '{w1: x, w2: z, w3: y, w4: x};
      315: ws = '{w1: y, w2: x, w3: x, w4: z};
      default: ws = '0;
    endcase
    return ws;
  endfunction

endpackage

// File: hw/quadGather.sv
`timescale 1ns/10ps

module quadGather (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pixelValid,
  input  imagePkg::pixelT pixel,
  input  logic            sof,
  input  imagePkg::pixelT rdData,
  output logic            wrEn,
  output imagePkg::colT   addr,
  output imagePkg::pixelT wrData,
  output logic            quadValid,
  output imagePkg::quadT  quad,
  output imagePkg::coordT quadCoord
);
  import imagePkg::*;

  colT   colCnt;
  rowT   rowCnt;
  colT   curCol;
  rowT   curRow;

  logic  curValid;
  pixelT curPixel;
  coordT curCoord;

  pixelT leftPixel;
  pixelT upLeftPixel;

  // Start of frame places this pixel at the origin.
  assign curCol = sof ? '0 : colCnt;
  assign curRow = sof ? '0 : rowCnt;

  assign wrEn   = pixelValid;
  assign addr   = curCol;
  assign wrData = pixel;

  // --------------------
  // Position counters
  // --------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      colCnt <= '0;
      rowCnt <= '0;
    end else if (pixelValid) begin
      if (curCol == colT'(imgWidth - 1)) begin
        colCnt <= '0;
        rowCnt <= curRow + 1'b1;
      end else begin
        colCnt <= curCol + 1'b1;
        rowCnt <= curRow;
      end
    end
  end

  // Stage 1 holds the current pixel while the row buffer read completes.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      curValid <= 1'b0;
      curPixel <= '0;
      curCoord <= '0;
    end else begin
      curValid <= pixelValid;
      if (pixelValid) begin
        curPixel <= pixel;
        curCoord <= '{row: curRow, col: curCol};
      end
    end
  end

  // --------------------
  // Window register
  // --------------------

  // The pixel above arrives from the row buffer now. The left and upper-left
  // pixels are what the previous step saw as current and above.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      quadValid   <= 1'b0;
      quad        <= '0;
      quadCoord   <= '0;
      leftPixel   <= '0;
      upLeftPixel <= '0;
    end else begin
      quadValid <= curValid && (curCoord.row != '0) && (curCoord.col != '0);
      if (curValid) begin
        quad        <= '{a: upLeftPixel, b: rdData, c: leftPixel, d: curPixel};
        quadCoord   <= curCoord;
        leftPixel   <= curPixel;
        upLeftPixel <= rdData;
      end
    end
  end

endmodule

// File: hw/rotSampler.sv
`timescale 1ns/10ps

module rotSampler (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 pixelValid,
  input  imagePkg::pixelT      pixel,
  input  logic                 sof,
  output logic                 sampleValid,
  output interpPkg::sampleSetT samples,
  output imagePkg::coordT      sampleCoord
);
  import imagePkg::*;
  import interpPkg::*;

  logic  wrEn;
  colT   addr;
  pixelT wrData;
  pixelT rdData;

  logic  quadValid;
  quadT  quad;
  coordT quadCoord;

  accT   r45;
  accT   r135;
  accT   r225;
  accT   r315;

  // --------------------
  // Window formation
  // --------------------

  quadGather uGather (
    .clk        (clk),
    .rst_n      (rst_n),
    .pixelValid (pixelValid),
    .pixel      (pixel),
    .sof        (sof),
    .rdData     (rdData),
    .wrEn       (wrEn),
    .addr       (addr),
    .wrData     (wrData),
    .quadValid  (quadValid),
    .quad       (quad),
    .quadCoord  (quadCoord)
  );

  rowBuffer uRowBuf (
    .clk    (clk),
    .rst_n  (rst_n),
    .wrEn   (wrEn),
    .addr   (addr),
    .wrData (wrData),
    .rdData (rdData)
  );

  // --------------------
  // Directional samples
  // --------------------

  bilinearInterp #(.angle(dirAngles[0])) uInterp45 (
    .clk    (clk),
    .rst_n  (rst_n),
    .quad   (quad),
    .result (r45)
  );

  bilinearInterp #(.angle(dirAngles[1])) uInterp135 (
    .clk    (clk),
    .rst_n  (rst_n),
    .quad   (quad),
    .result (r135)
  );

  bilinearInterp #(.angle(dirAngles[2])) uInterp225 (
    .clk    (clk),
    .rst_n  (rst_n),
    .quad   (quad),
    .result (r225)
  );

  bilinearInterp #(.angle(dirAngles[3])) uInterp315 (
    .clk    (clk),
    .rst_n  (rst_n),
    .quad   (quad),
    .result (r315)
  );

  sampleAssembler uAssembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .quadValid   (quadValid),
    .quadCoord   (quadCoord),
    .r45         (r45),
    .r135        (r135),
    .r225        (r225),
    .r315        (r315),
    .sampleValid (sampleValid),
    .samples     (samples),
    .sampleCoord (sampleCoord)
  );

endmodule

// File: hw/rowBuffer.sv
`timescale 1ns/10ps

module rowBuffer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wrEn,
  input  imagePkg::colT   addr,
  input  imagePkg::pixelT wrData,
  output imagePkg::pixelT rdData
);
  import imagePkg::*;

  pixelT mem [imgWidth];

  // The incoming pixel replaces the one from the row above.
  always_ff @(posedge clk) begin
    if (wrEn) begin
      mem[addr] <= wrData;
    end
  end

  // Read and write share the address, so the read returns the old row's
  // pixel at this column. It holds until the next write.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdData <= '0;
    end else if (wrEn) begin
      rdData <= mem[addr];
    end
  end

endmodule

// File: hw/sampleAssembler.sv
`timescale 1ns/10ps

module sampleAssembler (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 quadValid,
  input  imagePkg::coordT      quadCoord,
  input  interpPkg::accT       r45,
  input  interpPkg::accT       r135,
  input  interpPkg::accT       r225,
  input  interpPkg::accT       r315,
  output logic                 sampleValid,
  output interpPkg::sampleSetT samples,
  output imagePkg::coordT      sampleCoord
);
  import imagePkg::*;
  import interpPkg::*;

  // Matches the interpolator latency.
  localparam int delayLen = 4;

  typedef struct packed {
    logic  valid;
    coordT coord;
  } tagT;

  tagT   tagDly [delayLen];
  accT   results [numDirs];
  pixelT rounded [numDirs];

  // Round half up from Q16 and clip to the pixel range.
  function automatic pixelT roundPixel(input accT value);
    logic [24:0] biased;
    biased = {1'b0, value} + 25'h008000;
    return (biased[24:16] > 9'd255) ? 8'hFF : biased[23:16];
  endfunction

  assign results = '{r45, r135, r225, r315};

  for (genvar i = 0; i < numDirs; i++) begin : gRound
    assign rounded[i] = roundPixel(results[i]);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tagDly <= '{default: '0};
    end else begin
      tagDly[0] <= '{valid: quadValid, coord: quadCoord};
      for (int i = 1; i < delayLen; i++) begin
        tagDly[i] <= tagDly[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sampleValid <= 1'b0;
      samples     <= '0;
      sampleCoord <= '0;
    end else begin
      sampleValid <= tagDly[delayLen-1].valid;
      samples     <= '{s45: rounded[0], s135: rounded[1], s225: rounded[2], s315: rounded[3]};
      sampleCoord <= tagDly[delayLen-1].coord;
    end
  end

endmodule

// File: rotSampler.f
hw/imagePkg.sv
hw/interpPkg.sv
hw/rowBuffer.sv
hw/quadGather.sv
hw/bilinearInterp.sv
hw/sampleAssembler.sv
hw/rotSampler.sv
testbench/rotSampler_chk.sv
testbench/rotSamplerTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the rotSampler testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir

if ! verilator --binary --timing --assert \
    --top-module rotSamplerTb \
    --Mdir "$buildDir" \
    -f rotSampler.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! "./$buildDir/VrotSamplerTb"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without errors"
exit 0

// File: testbench/rotSamplerTb.sv
`timescale 1ns/10ps

module rotSamplerTb;
  import imagePkg::*;
  import interpPkg::*;

  localparam int constRows = 3;
  localparam int randRows = 6;
  localparam int leadPixels = 5;
  localparam int totalPixels = (constRows + randRows + 2) * imgWidth + leadPixels;
  // A pixel takes at most three cycles with gaps. Drain and settle time fit in the margin.
  localparam int cycleLimit = totalPixels * 3 + 100;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      pixelValid;
  pixelT     pixel;
  logic      sof;
  logic      sampleValid;
  sampleSetT samples;
  coordT     sampleCoord;

  logic [15:0] lfsr;
  int          cycleCount = 0;
  int          gotCount;
  string       curTest;
  logic        constMode;
  pixelT       constVal;

  // Reference model state.
  pixelT lineMem [imgWidth];
  pixelT leftPx;
  pixelT upLeftPx;
  colT   mCol;
  rowT   mRow;

  sampleSetT expSamples [$];
  coordT     expCoords [$];

  always #5 clk = ~clk;

  rotSampler uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixelValid  (pixelValid),
    .pixel       (pixel),
    .sof         (sof),
    .sampleValid (sampleValid),
    .samples     (samples),
    .sampleCoord (sampleCoord)
  );

  bind rotSampler rotSampler_chk uChk (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixelValid  (pixelValid),
    .sampleValid (sampleValid)
  );

  // --------------------
  // Random source
  // --------------------

  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [7:0] randBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[0]};
      lfsr = lfsrStep(lfsr);
    end
    return v;
  endfunction

  // --------------------
  // Reference model
  // --------------------

  // Q16 products and sums wrap at 24 bits, then the total rounds half up.
  function automatic pixelT expectedPixel(input quadT q, input int angle);
    weightSetT   w;
    logic [31:0] pa;
    logic [31:0] pb;
    logic [31:0] pc;
    logic [31:0] pd;
    accT         total;
    logic [31:0] scaled;
    w = dirWeights(angle, sampleRadius);
    pa = 32'(w.w1) * 32'(q.a);
    pb = 32'(w.w2) * 32'(q.b);
    pc = 32'(w.w3) * 32'(q.c);
    pd = 32'(w.w4) * 32'(q.d);
    total = accT'(accT'(pa[23:0] + pb[23:0]) + accT'(pc[23:0] + pd[23:0]));
    scaled = (32'(total) + 32'h8000) >> 16;
    return (scaled > 32'd255) ? 8'hFF : scaled[7:0];
  endfunction

  task automatic modelPixel(input pixelT p, input logic s);
    colT   colNow;
    rowT   rowNow;
    pixelT above;
    quadT  win;
    colNow = s ? colT'(0) : mCol;
    rowNow = s ? rowT'(0) : mRow;
    above = lineMem[colNow];
    if (rowNow != '0 && colNow != '0) begin
      win = quadT'{a: upLeftPx, b: above, c: leftPx, d: p};
      if (constMode) begin
        expSamples.push_back(sampleSetT'{s45: constVal, s135: constVal,
                                         s225: constVal, s315: constVal});
      end else begin
        expSamples.push_back(sampleSetT'{s45: expectedPixel(win, 45),
                                         s135: expectedPixel(win, 135),
                                         s225: expectedPixel(win, 225),
                                         s315: expectedPixel(win, 315)});
      end
      expCoords.push_back(coordT'{row: rowNow, col: colNow});
    end
    upLeftPx = above;
    leftPx = p;
    lineMem[colNow] = p;
    if (colNow == colT'(imgWidth - 1)) begin
      mCol = '0;
      mRow = rowNow + 1'b1;
    end else begin
      mCol = colNow + 1'b1;
      mRow = rowNow;
    end
  endtask

  // --------------------
  // Checks
  // --------------------

  task automatic stopWithError(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopping after the first error.");
  endtask

  task automatic checkSamples(input string testName, input sampleSetT exp,
                              input sampleSetT act);
    if (act !== exp) begin
      stopWithError($sformatf("MISMATCH %s samples expected %h actual %h",
                              testName, exp, act));
    end
  endtask

  task automatic checkCoord(input string testName, input coordT exp, input coordT act);
    if (act !== exp) begin
      stopWithError($sformatf("MISMATCH %s coord expected row %0d col %0d actual row %0d col %0d",
                              testName, exp.row, exp.col, act.row, act.col));
    end
  endtask

  task automatic checkCount(input string testName, input int exp, input int act);
    if (act != exp) begin
      stopWithError($sformatf("MISMATCH %s sample count expected %0d actual %0d",
                              testName, exp, act));
    end
  endtask

  // Outputs settle at the rising edge, so they are read half a cycle later.
  always @(negedge clk) begin
    if (rst_n === 1'b1 && sampleValid === 1'b1) begin
      if (expSamples.size() == 0) begin
        stopWithError($sformatf("%s: sampleValid came with no window pending", curTest));
      end else begin
        checkSamples(curTest, expSamples.pop_front(), samples);
        checkCoord(curTest, expCoords.pop_front(), sampleCoord);
        gotCount++;
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      stopWithError("The run did not finish within the cycle limit");
    end
  end

  // --------------------
  // Stimulus
  // --------------------

  task automatic idleCycle();
    @(posedge clk);
    #1;
    pixelValid = 1'b0;
    pixel = '0;
    sof = 1'b0;
  endtask

  task automatic drivePixel(input pixelT p, input logic s);
    @(posedge clk);
    #1;
    pixelValid = 1'b1;
    pixel = p;
    sof = s;
    modelPixel(p, s);
  endtask

  task automatic sendPixels(input int count, input logic firstSof, input logic withGaps);
    logic [7:0] gap;
    pixelT      p;
    for (int i = 0; i < count; i++) begin
      if (withGaps) begin
        gap = randBits(2);
        for (int g = 0; g < int'(gap) - 1; g++) begin
          idleCycle();
        end
      end
      p = constMode ? constVal : randBits(8);
      drivePixel(p, firstSof && (i == 0));
    end
    idleCycle();
  endtask

  task automatic finishTest(input int expectedCount);
    while (expSamples.size() != 0) begin
      @(posedge clk);
    end
    // Extra samples would show up in these quiet cycles.
    repeat (8) @(posedge clk);
    checkCount(curTest, expectedCount, gotCount);
  endtask

  initial begin
    lfsr = 16'd65;
    rst_n = 1'b0;
    pixelValid = 1'b0;
    pixel = '0;
    sof = 1'b0;
    gotCount = 0;
    curTest = "reset";
    constMode = 1'b0;
    constVal = '0;
    mCol = '0;
    mRow = '0;
    leftPx = '0;
    upLeftPx = '0;
    foreach (lineMem[i]) begin
      lineMem[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    curTest = "constFrame";
    constMode = 1'b1;
    constVal = randBits(8);
    gotCount = 0;
    sendPixels(constRows * imgWidth, 1'b1, 1'b0);
    finishTest((constRows - 1) * (imgWidth - 1));
    constMode = 1'b0;

    curTest = "randomFrame";
    gotCount = 0;
    sendPixels(randRows * imgWidth, 1'b1, 1'b1);
    finishTest((randRows - 1) * (imgWidth - 1));

    // The frame restarts a few pixels into a row.
    curTest = "midRowSof";
    gotCount = 0;
    sendPixels(leadPixels, 1'b0, 1'b1);
    sendPixels(2 * imgWidth, 1'b1, 1'b1);
    finishTest((leadPixels - 1) + (imgWidth - 1));

    if (expSamples.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stopWithError("Expected samples were still pending at the end of the run");
    end
  end

endmodule

// File: testbench/rotSampler_chk.sv
`timescale 1ns/10ps

module rotSampler_chk (
  input logic clk,
  input logic rst_n,
  input logic pixelValid,
  input logic sampleValid
);

  // --------------------
  // Top-level timing
  // --------------------

  // Reset clears the output strobe.
  resetQuiet: assert property (@(posedge clk) !rst_n |=> !sampleValid)
    else $error("sampleValid high right after a reset cycle");

  // No window can complete within seven cycles of reset release.
  noEarlySample: assert property (@(posedge clk) sampleValid |-> $past(rst_n, 7))
    else $error("sampleValid within seven cycles of reset release");

  // Every sample traces back to the pixel seven cycles before it.
  fixedLatency: assert property (
    @(posedge clk) disable iff (!rst_n) sampleValid |-> $past(pixelValid, 7))
    else $error("sampleValid without a pixelValid seven cycles earlier");

endmodule
